//--- rtl/fetch_unit.sv
module fetch_unit
    import tomasulo_pkg::*;
#(
    parameter rv32i_word reset_pc = reset_pc_default
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_mem_resp,
    input  rv32i_word instr_rdata,
    input  logic      iq_resp,
    output logic      instr_read,
    output rv32i_word instr_mem_address,
    output logic      ld_iq,
    output ctl_word_t iq_word
);

    typedef enum logic [1:0] {
        RESET,
        FETCH,
        CREATE,
        STALL
    } fetch_state_t;

    fetch_state_t state;
    fetch_state_t next_state;

    rv32i_word pc;          // address of the next fetch
    rv32i_word instr_q;     // fetched word waiting for the queue
    rv32i_word instr_pc_q;  // pc that word was fetched from
    logic      latch_instr;
    logic      ld_pc;

    assign instr_mem_address = pc;

    assign latch_instr = (state == FETCH) && instr_mem_resp;
    assign ld_pc       = (state == CREATE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    // pc moves on once the word has been captured
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (ld_pc) begin
            pc <= pc + 32'd4;
        end
    end

    // word and its own pc, held steady through a stall
    always_ff @(posedge clk) begin
        if (latch_instr) begin
            instr_q    <= instr_rdata;
            instr_pc_q <= pc;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET:  next_state = FETCH;
            FETCH: begin
                if (instr_mem_resp) begin
                    next_state = CREATE;
                end
            end
            CREATE: next_state = iq_resp ? FETCH : STALL;
            STALL: begin
                if (iq_resp) begin
                    next_state = FETCH; // queue took the word
                end
            end
            default: next_state = RESET;
        endcase
    end

    // outputs are pure functions of state
    always_comb begin
        instr_read = 1'b0;
        ld_iq      = 1'b0;
        case (state)
            FETCH:  instr_read = 1'b1;
            CREATE: ld_iq      = 1'b1;
            STALL:  ld_iq      = 1'b1; // keep offering until accepted
            default: begin
                instr_read = 1'b0;
                ld_iq      = 1'b0;
            end
        endcase
    end

    instr_decoder i_instr_decoder (
        .instr    (instr_q),
        .pc       (instr_pc_q),
        .ctl_word (iq_word)
    );

endmodule

//--- rtl/instr_decoder.sv
module instr_decoder
    import tomasulo_pkg::*;
(
    input  rv32i_word instr,
    input  rv32i_word pc,
    output ctl_word_t ctl_word
);

    rv32i_opcode opcode;
    rv32i_word   i_imm;
    rv32i_word   s_imm;
    rv32i_word   b_imm;
    rv32i_word   u_imm;
    rv32i_word   j_imm;

    op_class_t   op_class;
    rv32i_word   imm;
    logic        imm_valid;

    assign opcode = rv32i_opcode'(instr[6:0]);

    // immediate formats, all sign extended from instr[31]
    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // op class and immediate selection
    always_comb begin
        op_class  = ARITH;
        imm       = '0;
        imm_valid = 1'b0;
        case (opcode)
            op_lui: begin
                op_class  = LUI;
                imm       = u_imm;
                imm_valid = 1'b1;
            end
            op_auipc: begin
                op_class  = AUIPC;
                imm       = u_imm;
                imm_valid = 1'b1;
            end
            op_jal: begin
                op_class  = JAL;
                imm       = j_imm;
                imm_valid = 1'b1;
            end
            op_jalr: begin
                op_class  = JALR;
                imm       = i_imm;
                imm_valid = 1'b1;
            end
            op_br: begin
                op_class  = BRANCH;
                imm       = b_imm;
                imm_valid = 1'b1;
            end
            op_load: begin
                op_class  = LD;
                imm       = i_imm;
                imm_valid = 1'b1;
            end
            op_store: begin
                op_class  = ST;
                imm       = s_imm;
                imm_valid = 1'b1;
            end
            op_imm, op_csr: begin
                // csr ops go down the alu path with the i-immediate
                imm       = i_imm; // class stays ARITH
                imm_valid = 1'b1;
            end
            default: begin
                // reg-reg and unknown opcodes, rename supplies the second operand
                imm       = '0;
                imm_valid = 1'b0;
            end
        endcase
    end

    // assemble the control word
    always_comb begin
        ctl_word.op         = op_class;
        ctl_word.src1_reg   = instr[19:15];
        ctl_word.src2_reg   = instr[24:20];
        ctl_word.rd         = instr[11:7];
        ctl_word.funct3     = instr[14:12];
        ctl_word.funct7     = instr[30]; // add/sub, srl/sra select
        ctl_word.src2_data  = imm;
        ctl_word.src2_valid = imm_valid;
        ctl_word.pc         = pc;
    end

endmodule

//--- rtl/instr_queue.sv
module instr_queue #(
    parameter type payload_t = logic [31:0],
    parameter int  iq_depth  = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     ld_iq,
    input  payload_t iq_word,
    input  logic     iq_pop,
    output logic     iq_resp,
    output logic     iq_valid,
    output payload_t iq_head
);

    localparam int ptr_w = (iq_depth > 1) ? $clog2(iq_depth) : 1;
    localparam int cnt_w = $clog2(iq_depth + 1);

    localparam logic [ptr_w-1:0] last_idx   = ptr_w'(iq_depth - 1);
    localparam logic [cnt_w-1:0] full_count = cnt_w'(iq_depth);

    payload_t entries [iq_depth];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;  // occupancy
    logic             full;
    logic             empty;
    logic             push;
    logic             pop;

    assign full  = (count == full_count);
    assign empty = (count == '0);

    // full is judged before any pop of the same cycle
    assign push = ld_iq && !full;
    assign pop  = iq_pop && !empty; // pop on empty is dropped

    assign iq_resp  = push;
    assign iq_valid = !empty;
    assign iq_head  = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= iq_word;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == last_idx) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_idx) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

endmodule

//--- rtl/rv32i_frontend.sv
module rv32i_frontend
    import tomasulo_pkg::*;
#(
    parameter rv32i_word reset_pc = reset_pc_default,
    parameter int        iq_depth = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      instr_mem_resp,
    input  rv32i_word instr_rdata,
    input  logic      iq_pop,
    output logic      instr_read,
    output rv32i_word instr_mem_address,
    output logic      iq_valid,
    output ctl_word_t iq_head
);

    // fetch to queue handshake
    logic      ld_iq;
    logic      iq_resp;
    ctl_word_t iq_word;

    fetch_unit #(
        .reset_pc (reset_pc)
    ) i_fetch_unit (
        .clk               (clk),
        .rst               (rst),
        .instr_mem_resp    (instr_mem_resp),
        .instr_rdata       (instr_rdata),
        .iq_resp           (iq_resp),
        .instr_read        (instr_read),
        .instr_mem_address (instr_mem_address),
        .ld_iq             (ld_iq),
        .iq_word           (iq_word)
    );

    instr_queue #(
        .payload_t (ctl_word_t),
        .iq_depth  (iq_depth)
    ) i_instr_queue (
        .clk      (clk),
        .rst      (rst),
        .ld_iq    (ld_iq),
        .iq_word  (iq_word),
        .iq_pop   (iq_pop),
        .iq_resp  (iq_resp),
        .iq_valid (iq_valid),
        .iq_head  (iq_head)
    );

endmodule

//--- rtl/tomasulo_pkg.sv
package tomasulo_pkg;

    // instructions, addresses and data all share one width
    typedef logic [31:0] rv32i_word;

    localparam rv32i_word reset_pc_default = 32'h0000_0000; // first fetch address

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111, // load upper immediate
        op_auipc = 7'b0010111, // add upper immediate to pc
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011, // conditional branches
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011, // reg-imm alu ops
        op_reg   = 7'b0110011, // reg-reg alu ops
        op_csr   = 7'b1110011  // system and csr
    } rv32i_opcode;

    // which reservation station the word is headed for
    typedef enum logic [2:0] {
        ARITH,
        LUI,
        AUIPC,
        JAL,
        JALR,
        BRANCH,
        LD,
        ST
    } op_class_t;

    // decoded instruction as it sits in the instruction queue
    typedef struct packed {
        op_class_t op;
        logic [4:0] src1_reg;
        logic [4:0] src2_reg;
        logic [4:0] rd;
        logic [2:0] funct3;
        logic       funct7;     // only instr[30] matters for rv32i
        rv32i_word  src2_data;  // immediate operand when src2_valid
        logic       src2_valid;
        rv32i_word  pc;         // pc of this instruction
    } ctl_word_t;

endpackage

//--- rv32i_frontend.f
rtl/tomasulo_pkg.sv
rtl/instr_decoder.sv
rtl/fetch_unit.sv
rtl/instr_queue.sv
rtl/rv32i_frontend.sv
verification/frontend_assertions.sv
verification/tb_rv32i_frontend.sv

//--- verification/frontend_assertions.sv
module frontend_assertions
    import tomasulo_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      instr_read,
    input rv32i_word instr_mem_address,
    input logic      ld_iq,
    input logic      iq_resp,
    input logic      full
);
    timeunit 1ns;
    timeprecision 1ps;

    // an offered word is held until the queue takes it
    ld_iq_held: assert property (@(posedge clk) disable iff (rst)
        ld_iq && !iq_resp |=> ld_iq)
        else $error("ld_iq dropped before iq_resp");

    addr_stable: assert property (@(posedge clk) disable iff (rst)
        instr_read && $past(instr_read) |-> $stable(instr_mem_address))
        else $error("instr_mem_address changed during a fetch");

    // accept only with a free slot
    no_resp_when_full: assert property (@(posedge clk) disable iff (rst)
        iq_resp |-> !full)
        else $error("iq_resp while the queue is full");

    read_ld_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(instr_read && ld_iq))
        else $error("instr_read and ld_iq high together");

endmodule

//--- verification/tb_rv32i_frontend.sv
module tb_rv32i_frontend
    import tomasulo_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_instr = 64;

    logic      clk;
    logic      rst;
    logic      instr_mem_resp;
    rv32i_word instr_rdata;
    logic      iq_pop;
    logic      instr_read;
    rv32i_word instr_mem_address;
    logic      iq_valid;
    ctl_word_t iq_head;

    rv32i_word   program_mem [n_instr];
    logic [31:0] lfsr = 32'h94a3_ffd6;
    int          mismatch_count = 0;
    int          failure_count = 0;
    int          pop_count = 0;
    int          full_pops = 0;   // pops while fetch was refused by a full queue
    int          stall_cycles = 0;
    logic        mem_busy = 1'b0;
    int          mem_wait = 0;
    int          hold_left = 0;

    rv32i_frontend #(
        .reset_pc (32'h0000_0000),
        .iq_depth (4)
    ) i_dut (
        .clk               (clk),
        .rst               (rst),
        .instr_mem_resp    (instr_mem_resp),
        .instr_rdata       (instr_rdata),
        .iq_pop            (iq_pop),
        .instr_read        (instr_read),
        .instr_mem_address (instr_mem_address),
        .iq_valid          (iq_valid),
        .iq_head           (iq_head)
    );

    bind fetch_unit frontend_assertions i_fetch_sva (
        .clk (clk), .rst (rst), .instr_read (instr_read),
        .instr_mem_address (instr_mem_address), .ld_iq (ld_iq),
        .iq_resp (iq_resp), .full (1'b0)
    );
    // fullness seen from the pointers, not from the count compare
    bind instr_queue frontend_assertions i_queue_sva (
        .clk (clk), .rst (rst), .instr_read (1'b0),
        .instr_mem_address (32'h0), .ld_iq (ld_iq),
        .iq_resp (iq_resp), .full ((wr_ptr == rd_ptr) && (count != '0))
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic ctl_word_t decode_ref(input rv32i_word w, input rv32i_word pc);
        ctl_word_t c;
        c.src1_reg   = w[19:15];
        c.src2_reg   = w[24:20];
        c.rd         = w[11:7];
        c.funct3     = w[14:12];
        c.funct7     = w[30];
        c.pc         = pc;
        c.op         = ARITH;
        c.src2_data  = 32'h0;
        c.src2_valid = 1'b1;
        case (w[6:0])
            op_lui: begin
                c.op        = LUI;
                c.src2_data = {w[31:12], 12'b0};
            end
            op_auipc: begin
                c.op        = AUIPC;
                c.src2_data = {w[31:12], 12'b0};
            end
            op_jal: begin
                c.op = JAL;
                c.src2_data = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            op_jalr: begin
                c.op        = JALR;
                c.src2_data = {{20{w[31]}}, w[31:20]};
            end
            op_br: begin
                c.op = BRANCH;
                c.src2_data = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            op_load: begin
                c.op        = LD;
                c.src2_data = {{20{w[31]}}, w[31:20]};
            end
            op_store: begin
                c.op        = ST;
                c.src2_data = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            op_imm, op_csr: c.src2_data = {{20{w[31]}}, w[31:20]};
            default: c.src2_valid = 1'b0; // reg-reg and unknown opcodes
        endcase
        return c;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s actual %h expected %h", $time, name, actual,
                     expected);
        end
    endtask

    // every class in turn, plus fence as an opcode the decoder does not know
    task automatic build_program();
        logic [6:0]  opcodes [11];
        logic [31:0] fields;
        opcodes = '{op_lui, op_auipc, op_jal, op_jalr, op_br, op_load, op_store,
                    op_imm, op_reg, op_csr, 7'b0001111};
        for (int i = 0; i < n_instr; i++) begin
            fields = rand_bits(25);
            program_mem[i] = {fields[24:0], opcodes[i % 11]};
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // memory model and consumer share one process so the lfsr order is fixed
    always @(posedge clk) begin
        if (!rst) begin
            #1;
            instr_mem_resp = 1'b0;
            instr_rdata    = 32'h0;
            if (instr_read) begin
                if (!mem_busy) begin
                    mem_busy = 1'b1;
                    mem_wait = rand_bits(2); // 0 to 3 cycles
                end
                if (mem_wait == 0) begin
                    instr_mem_resp = 1'b1;
                    instr_rdata = (instr_mem_address[31:2] < n_instr) ?
                                  program_mem[instr_mem_address[7:2]] : 32'h0000_0013;
                    mem_busy = 1'b0;
                end else begin
                    mem_wait--;
                end
            end
            if (pop_count >= n_instr) begin
                iq_pop = 1'b0;
            end else if (hold_left > 0) begin
                hold_left--;
                iq_pop = (hold_left == 0); // first pop after a hold meets a full queue
            end else if (rand_bits(3) == 0) begin
                hold_left = 16 + rand_bits(4);
                iq_pop = 1'b0;
            end else begin
                iq_pop = (rand_bits(1) != 0);
            end
        end
    end

    // compare at the falling edge, the pop lands at the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (i_dut.ld_iq && !i_dut.iq_resp) begin
                stall_cycles++;
                if (iq_valid && iq_pop) full_pops++;
            end
            if (iq_valid && iq_pop && pop_count < n_instr) begin
                ctl_word_t exp;
                exp = decode_ref(program_mem[pop_count], 32'(pop_count * 4));
                check_value("iq_head.op", iq_head.op, exp.op);
                check_value("iq_head.src1_reg", iq_head.src1_reg, exp.src1_reg);
                check_value("iq_head.src2_reg", iq_head.src2_reg, exp.src2_reg);
                check_value("iq_head.rd", iq_head.rd, exp.rd);
                check_value("iq_head.funct3", iq_head.funct3, exp.funct3);
                check_value("iq_head.funct7", iq_head.funct7, exp.funct7);
                check_value("iq_head.src2_data", iq_head.src2_data, exp.src2_data);
                check_value("iq_head.src2_valid", iq_head.src2_valid, exp.src2_valid);
                check_value("iq_head.pc", iq_head.pc, exp.pc);
                pop_count++;
            end
        end
    end

    initial begin
        #(n_instr * (2 + 3 + 6) * 8 * 2);
        $display("timeout: only %0d of %0d instructions popped", pop_count, n_instr);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst            = 1'b1;
        instr_mem_resp = 1'b0;
        instr_rdata    = 32'h0;
        iq_pop         = 1'b0;
        build_program();
        repeat (8) begin
            @(posedge clk);
            #1;
            check_value("instr_read", instr_read, 1'b0);
            check_value("iq_valid", iq_valid, 1'b0);
        end
        rst = 1'b0;
        check_value("instr_read", instr_read, 1'b0);
        check_value("iq_valid", iq_valid, 1'b0);
        while (!instr_read) @(negedge clk);
        check_value("instr_mem_address", instr_mem_address, 32'h0);
        wait (pop_count == n_instr);
        repeat (2) @(posedge clk);
        if (stall_cycles == 0) begin
            failure_count++;
            $display("fetch never stalled on a full queue");
        end
        if (full_pops == 0) begin
            failure_count++;
            $display("no pop ever happened while the queue was full");
        end
        $display("mismatches: %0d, other failures: %0d, stall cycles: %0d, full-queue pops: %0d",
                 mismatch_count, failure_count, stall_cycles, full_pops);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
